// File: src/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

  // one frame on the wire: start, data lsb first, odd parity, stop
  localparam int data_bits  = 8;
  localparam int frame_bits = 11;

  // wide enough to index every bit of a frame
  localparam int bit_cnt_w = 4;

  // bit times a read waits for its answer
  localparam int resp_timeout_bits = 64;

  typedef logic [data_bits-1:0] byte_t;

endpackage

`default_nettype wire

// File: src/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // wishbone geometry
  localparam int wb_addr_w = 2;
  localparam int wb_data_w = 16;

  // command word, bit 15 set for a write
  typedef logic [15:0] cmd_t;
  localparam int cmd_write_bit = 15;

  // word addresses
  localparam logic [wb_addr_w-1:0] addr_cmd    = 2'd0;
  localparam logic [wb_addr_w-1:0] addr_status = 2'd1;
  localparam logic [wb_addr_w-1:0] addr_rdata  = 2'd2;

  // status register bits
  localparam int st_busy        = 0;
  localparam int st_rdata_valid = 1;
  localparam int st_parity_err  = 2;
  localparam int st_frame_err   = 3;
  localparam int st_timeout     = 4;

endpackage

`default_nettype wire

// File: src/uart_tx.sv
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_start,
  input  uart_frame_pkg::byte_t tx_byte,
  output logic                  tx,
  output logic                  tx_busy
);

  localparam int baud_w   = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  // start bit is driven directly, the rest waits in the shift register
  localparam int sr_w     = uart_frame_pkg::frame_bits - 1;
  localparam int last_bit = uart_frame_pkg::frame_bits - 1;

  logic [sr_w-1:0]                      frame_sr;
  logic [baud_w-1:0]                    baud_cnt;
  logic [uart_frame_pkg::bit_cnt_w-1:0] bit_cnt;
  logic                                 parity;
  logic                                 bit_end;

  // odd parity over data plus parity bit
  assign parity  = ~^tx_byte;
  assign bit_end = (baud_cnt == baud_w'(clks_per_bit - 1));

  // stop and parity above the data, ones shifted in behind
  always_ff @(posedge clk) begin
    if (tx_start && !tx_busy) begin
      frame_sr <= {1'b1, parity, tx_byte};
    end else if (tx_busy && bit_end) begin
      frame_sr <= {1'b1, frame_sr[sr_w-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // start bit goes out right away
        tx       <= 1'b0;
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_cnt == uart_frame_pkg::bit_cnt_w'(last_bit)) begin
        // end of stop bit, back to idle
        tx      <= 1'b1;
        tx_busy <= 1'b0;
      end else begin
        tx      <= frame_sr[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`default_nettype none

module uart_rx #(
  parameter int clks_per_bit = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  output uart_frame_pkg::byte_t rx_byte,
  output logic                  rx_valid,
  output logic                  rx_parity_err,
  output logic                  rx_frame_err
);

  localparam int baud_w     = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int data_bits  = uart_frame_pkg::data_bits;
  localparam int parity_bit = data_bits + 1;
  localparam int last_bit   = uart_frame_pkg::frame_bits - 1;
  // first sample lands half a bit after the detected edge
  localparam int half_load  = clks_per_bit - clks_per_bit / 2;

  logic [2:0]                           rx_sync;
  logic                                 rx_s;
  logic                                 rx_fall;
  logic                                 active;
  logic                                 sample;
  logic [baud_w-1:0]                    baud_cnt;
  logic [uart_frame_pkg::bit_cnt_w-1:0] bit_idx;
  uart_frame_pkg::byte_t                data_sr;
  logic                                 parity_q;
  logic                                 in_data;

  // line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  assign rx_s    = rx_sync[1];
  assign rx_fall = rx_sync[2] & ~rx_sync[1];
  assign sample  = active && (baud_cnt == baud_w'(clks_per_bit - 1));
  assign in_data = (bit_idx >= uart_frame_pkg::bit_cnt_w'(1)) &&
                   (bit_idx <= uart_frame_pkg::bit_cnt_w'(data_bits));
  assign rx_byte = data_sr;

  // data arrives lsb first
  always_ff @(posedge clk) begin
    if (sample) begin
      if (in_data) begin
        data_sr <= {rx_s, data_sr[data_bits-1:1]};
      end
      if (bit_idx == uart_frame_pkg::bit_cnt_w'(parity_bit)) begin
        parity_q <= rx_s;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active        <= 1'b0;
      baud_cnt      <= '0;
      bit_idx       <= '0;
      rx_valid      <= 1'b0;
      rx_parity_err <= 1'b0;
      rx_frame_err  <= 1'b0;
    end else begin
      rx_valid      <= 1'b0;
      rx_parity_err <= 1'b0;
      rx_frame_err  <= 1'b0;
      if (!active) begin
        if (rx_fall) begin
          active   <= 1'b1;
          baud_cnt <= baud_w'(half_load);
          bit_idx  <= '0;
        end
      end else if (sample) begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_s) begin
          // start bit gone by mid-bit, treat as a glitch
          active <= 1'b0;
        end else if (bit_idx == uart_frame_pkg::bit_cnt_w'(last_bit)) begin
          active <= 1'b0;
          if (rx_s) begin
            rx_valid      <= 1'b1;
            rx_parity_err <= ~^{parity_q, data_sr};
          end else begin
            rx_frame_err <= 1'b1;
          end
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/cmd_sequencer.sv
`default_nettype none

module cmd_sequencer #(
  parameter int clks_per_bit = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_start,
  input  uart_cmd_pkg::cmd_t    cmd_word,
  output logic                  busy,
  output logic                  done,
  output uart_frame_pkg::byte_t resp_byte,
  output logic                  resp_valid,
  output logic                  parity_err,
  output logic                  frame_err,
  output logic                  timeout,
  output logic                  tx_start,
  output uart_frame_pkg::byte_t tx_byte,
  input  logic                  tx_busy,
  input  uart_frame_pkg::byte_t rx_byte,
  input  logic                  rx_valid,
  input  logic                  rx_parity_err,
  input  logic                  rx_frame_err
);

  localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int tmo_w  = $clog2(uart_frame_pkg::resp_timeout_bits);

  typedef enum logic [2:0] {
    st_idle,
    st_send_hi,
    st_send_lo,
    st_wait_resp,
    st_finish
  } state_t;

  state_t             state;
  uart_cmd_pkg::cmd_t cmd_q;
  logic               tx_busy_q;
  logic               frame_done;
  logic               is_write;
  logic               bit_tick;
  logic               tmo_hit;
  logic [baud_w-1:0]  baud_cnt;
  logic [tmo_w-1:0]   tmo_cnt;

  assign is_write   = cmd_q[uart_cmd_pkg::cmd_write_bit];
  assign frame_done = tx_busy_q & ~tx_busy;
  assign bit_tick   = (baud_cnt == baud_w'(clks_per_bit - 1));
  assign tmo_hit    = bit_tick &&
                      (tmo_cnt == tmo_w'(uart_frame_pkg::resp_timeout_bits - 1));

  assign busy = (state != st_idle);
  assign done = (state == st_finish);

  // high byte leaves with cmd_start, low byte right behind the first frame
  always_comb begin
    tx_start = 1'b0;
    tx_byte  = cmd_q[7:0];
    if (state == st_idle) begin
      tx_start = cmd_start;
      tx_byte  = cmd_word[15:8];
    end else if (state == st_send_hi) begin
      tx_start = frame_done & is_write;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && cmd_start) begin
      cmd_q <= cmd_word;
    end
    if (state == st_wait_resp && rx_valid) begin
      resp_byte <= rx_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      tx_busy_q  <= 1'b0;
      baud_cnt   <= '0;
      tmo_cnt    <= '0;
      resp_valid <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
      timeout    <= 1'b0;
    end else begin
      tx_busy_q  <= tx_busy;
      resp_valid <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
      timeout    <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_start) begin
            state <= st_send_hi;
          end
        end
        st_send_hi: begin
          if (frame_done) begin
            if (is_write) begin
              state <= st_send_lo;
            end else begin
              state    <= st_wait_resp;
              baud_cnt <= '0;
              tmo_cnt  <= '0;
            end
          end
        end
        st_send_lo: begin
          if (frame_done) begin
            state <= st_finish;
          end
        end
        st_wait_resp: begin
          if (rx_valid) begin
            // byte still kept on a parity error, just not flagged valid
            state      <= st_finish;
            resp_valid <= ~rx_parity_err;
            parity_err <= rx_parity_err;
          end else if (rx_frame_err) begin
            state     <= st_finish;
            frame_err <= 1'b1;
          end else if (tmo_hit) begin
            state   <= st_finish;
            timeout <= 1'b1;
          end else if (bit_tick) begin
            baud_cnt <= '0;
            tmo_cnt  <= tmo_cnt + 1'b1;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        st_finish: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/wb_cmd_regs.sv
`default_nettype none

module wb_cmd_regs (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [uart_cmd_pkg::wb_addr_w-1:0]   wb_adr,
  input  logic [uart_cmd_pkg::wb_data_w-1:0]   wb_dat_w,
  output logic [uart_cmd_pkg::wb_data_w-1:0]   wb_dat_r,
  output logic                                 wb_ack,
  output logic                                 cmd_start,
  output uart_cmd_pkg::cmd_t                   cmd_word,
  input  logic                                 busy,
  input  logic                                 done,
  input  uart_frame_pkg::byte_t                resp_byte,
  input  logic                                 resp_valid,
  input  logic                                 parity_err,
  input  logic                                 frame_err,
  input  logic                                 timeout
);

  localparam int dw = uart_cmd_pkg::wb_data_w;

  logic                  access;
  logic                  cmd_accept;
  logic                  rd_rdata;
  logic                  rdata_valid;
  logic                  parity_sticky;
  logic                  frame_sticky;
  logic                  timeout_sticky;
  uart_frame_pkg::byte_t rdata_q;
  logic [dw-1:0]         status_word;
  logic [dw-1:0]         read_mux;

  // a new request is taken only outside the ack cycle
  assign access     = wb_cyc & wb_stb & ~wb_ack;
  assign cmd_accept = access & wb_we & (wb_adr == uart_cmd_pkg::addr_cmd) & ~busy;
  assign rd_rdata   = access & ~wb_we & (wb_adr == uart_cmd_pkg::addr_rdata);

  always_comb begin
    status_word = '0;
    status_word[uart_cmd_pkg::st_busy]        = busy;
    status_word[uart_cmd_pkg::st_rdata_valid] = rdata_valid;
    status_word[uart_cmd_pkg::st_parity_err]  = parity_sticky;
    status_word[uart_cmd_pkg::st_frame_err]   = frame_sticky;
    status_word[uart_cmd_pkg::st_timeout]     = timeout_sticky;
  end

  // command register reads back as zero
  always_comb begin
    case (wb_adr)
      uart_cmd_pkg::addr_status: read_mux = status_word;
      uart_cmd_pkg::addr_rdata:  read_mux = dw'(rdata_q);
      default:                   read_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access && !wb_we) begin
      wb_dat_r <= read_mux;
    end
    if (cmd_accept) begin
      cmd_word <= wb_dat_w;
    end
    if (done && (resp_valid || parity_err)) begin
      rdata_q <= resp_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack         <= 1'b0;
      cmd_start      <= 1'b0;
      rdata_valid    <= 1'b0;
      parity_sticky  <= 1'b0;
      frame_sticky   <= 1'b0;
      timeout_sticky <= 1'b0;
    end else begin
      wb_ack    <= access;
      cmd_start <= cmd_accept;
      if (cmd_accept) begin
        // fresh command starts with a clean status
        rdata_valid    <= 1'b0;
        parity_sticky  <= 1'b0;
        frame_sticky   <= 1'b0;
        timeout_sticky <= 1'b0;
      end else begin
        if (rd_rdata) begin
          rdata_valid <= 1'b0;
        end
        // events arrive together with done, new data wins over a read clear
        if (done) begin
          if (resp_valid) begin
            rdata_valid <= 1'b1;
          end
          parity_sticky  <= parity_sticky | parity_err;
          frame_sticky   <= frame_sticky | frame_err;
          timeout_sticky <= timeout_sticky | timeout;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/uart_cmd_top.sv
`default_nettype none

module uart_cmd_top #(
  parameter int clks_per_bit = 16
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [uart_cmd_pkg::wb_addr_w-1:0] wb_adr,
  input  logic [uart_cmd_pkg::wb_data_w-1:0] wb_dat_w,
  output logic [uart_cmd_pkg::wb_data_w-1:0] wb_dat_r,
  output logic                               wb_ack,
  output logic                               tx,
  input  logic                               rx
);

  // register block to sequencer
  logic                  cmd_start;
  uart_cmd_pkg::cmd_t    cmd_word;
  logic                  busy;
  logic                  done;
  uart_frame_pkg::byte_t resp_byte;
  logic                  resp_valid;
  logic                  parity_err;
  logic                  frame_err;
  logic                  timeout;

  // serial side
  logic                  tx_start;
  uart_frame_pkg::byte_t tx_byte;
  logic                  tx_busy;
  uart_frame_pkg::byte_t rx_byte;
  logic                  rx_valid;
  logic                  rx_parity_err;
  logic                  rx_frame_err;

  wb_cmd_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .cmd_start  (cmd_start),
    .cmd_word   (cmd_word),
    .busy       (busy),
    .done       (done),
    .resp_byte  (resp_byte),
    .resp_valid (resp_valid),
    .parity_err (parity_err),
    .frame_err  (frame_err),
    .timeout    (timeout)
  );

  cmd_sequencer #(
    .clks_per_bit (clks_per_bit)
  ) u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_start     (cmd_start),
    .cmd_word      (cmd_word),
    .busy          (busy),
    .done          (done),
    .resp_byte     (resp_byte),
    .resp_valid    (resp_valid),
    .parity_err    (parity_err),
    .frame_err     (frame_err),
    .timeout       (timeout),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

`default_nettype wire

// File: verif/uart_peer_model.sv
`default_nettype none

module uart_peer_model #(
  parameter int clks_per_bit = 16
) (
  input  logic                  clk,
  input  logic                  tx,
  input  logic                  bad_parity,
  input  logic                  silent,
  output logic                  rx,
  output logic                  got_valid,
  output uart_frame_pkg::byte_t got_byte,
  output logic                  got_par_ok,
  output logic                  got_stop_ok
);

  uart_frame_pkg::byte_t answer;
  logic                  want_low;
  event                  answer_ev;

  // one frame on rx, 3 bit times after the command byte
  task automatic send_frame(input uart_frame_pkg::byte_t data);
    logic parity;
    parity = ~^data;
    repeat (3 * clks_per_bit) @(negedge clk);
    rx = 1'b0;
    repeat (clks_per_bit) @(negedge clk);
    for (int i = 0; i < uart_frame_pkg::data_bits; i++) begin
      rx = data[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    rx = parity ^ bad_parity;
    repeat (clks_per_bit) @(negedge clk);
    rx = 1'b1;
    repeat (clks_per_bit) @(negedge clk);
  endtask

  // decode frames on tx at mid-bit
  initial begin
    uart_frame_pkg::byte_t b;
    logic p;
    logic s;
    got_valid   = 1'b0;
    got_byte    = '0;
    got_par_ok  = 1'b0;
    got_stop_ok = 1'b0;
    want_low    = 1'b0;
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (clks_per_bit / 2) @(negedge clk);
        if (tx === 1'b0) begin
          for (int i = 0; i < uart_frame_pkg::data_bits; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            b[i] = tx;
          end
          repeat (clks_per_bit) @(negedge clk);
          p = tx;
          repeat (clks_per_bit) @(negedge clk);
          s = tx;
          got_byte    = b;
          got_par_ok  = ^{p, b};
          got_stop_ok = (s === 1'b1);
          got_valid   = 1'b1;
          @(negedge clk);
          got_valid = 1'b0;
          // bit 7 of the first byte is the write flag
          if (want_low) begin
            want_low = 1'b0;
          end else if (b[7]) begin
            want_low = 1'b1;
          end else if (!silent) begin
            answer = tb_uart_cmd.peer_response(b);
            -> answer_ev;
          end
        end
      end
    end
  end

  initial begin
    rx = 1'b1;
    forever begin
      @(answer_ev);
      send_frame(answer);
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_uart_cmd.sv
`default_nettype none

module tb_uart_cmd;

  localparam int clks_per_bit = 16;
  localparam int frame_cycles = uart_frame_pkg::frame_bits * clks_per_bit;
  // 40 commands of two frames and a full response wait each
  localparam int cycle_limit =
    40 * (2 + uart_frame_pkg::resp_timeout_bits) * frame_cycles + 20000;

  logic                               clk;
  logic                               rst_n;
  logic                               wb_cyc;
  logic                               wb_stb;
  logic                               wb_we;
  logic [uart_cmd_pkg::wb_addr_w-1:0] wb_adr;
  logic [uart_cmd_pkg::wb_data_w-1:0] wb_dat_w;
  logic [uart_cmd_pkg::wb_data_w-1:0] wb_dat_r;
  logic                               wb_ack;
  logic                               tx;
  logic                               rx;
  logic                               bad_parity;
  logic                               silent;
  logic                               got_valid;
  uart_frame_pkg::byte_t              got_byte;
  logic                               got_par_ok;
  logic                               got_stop_ok;

  uart_frame_pkg::byte_t exp_q[$];
  uart_frame_pkg::byte_t want_byte;
  int                    errors = 0;
  int                    pass_count = 0;
  int                    fail_count = 0;
  int                    test_num = 0;
  int                    test_first_error = 0;
  string                 test_name;
  int                    cycles = 0;

  uart_cmd_top #(
    .clks_per_bit (clks_per_bit)
  ) uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .tx       (tx),
    .rx       (rx)
  );

  uart_peer_model #(
    .clks_per_bit (clks_per_bit)
  ) peer (
    .clk         (clk),
    .tx          (tx),
    .bad_parity  (bad_parity),
    .silent      (silent),
    .rx          (rx),
    .got_valid   (got_valid),
    .got_byte    (got_byte),
    .got_par_ok  (got_par_ok),
    .got_stop_ok (got_stop_ok)
  );

  // the remote device answers a read with the high byte xor 5a
  function automatic uart_frame_pkg::byte_t peer_response(input uart_frame_pkg::byte_t hi);
    return hi ^ 8'h5a;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run went past %0d clock cycles without finishing", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_true(input logic ok, input string msg);
    assert (ok === 1'b1) else begin
      $display("CHECK FAILED t=%0t %s", $time, msg);
      errors++;
    end
  endtask

  // every frame the peer sees must be the next expected byte
  always @(posedge clk) begin
    if (got_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        check_true(1'b0, $sformatf("unexpected byte %02h on tx", got_byte));
      end else begin
        want_byte = exp_q.pop_front();
        check_true(got_byte == want_byte,
                   $sformatf("tx byte %02h, expected %02h", got_byte, want_byte));
        check_true(got_par_ok, $sformatf("bad parity on tx byte %02h", got_byte));
        check_true(got_stop_ok, $sformatf("bad stop bit on tx byte %02h", got_byte));
      end
    end
  end

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    @(negedge clk);
    check_true(wb_ack === 1'b1, "wb_ack missing one cycle after the write strobe");
    while (wb_ack !== 1'b1) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [15:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    check_true(wb_ack === 1'b1, "wb_ack missing one cycle after the read strobe");
    while (wb_ack !== 1'b1) @(negedge clk);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wait_not_busy(output logic [15:0] status);
    wb_read(uart_cmd_pkg::addr_status, status);
    while (status[uart_cmd_pkg::st_busy] !== 1'b0) begin
      wb_read(uart_cmd_pkg::addr_status, status);
    end
  endtask

  task automatic issue_command(input uart_cmd_pkg::cmd_t cmd);
    exp_q.push_back(cmd[15:8]);
    if (cmd[uart_cmd_pkg::cmd_write_bit]) begin
      exp_q.push_back(cmd[7:0]);
    end
    wb_write(uart_cmd_pkg::addr_cmd, cmd);
  endtask

  task automatic run_write(input uart_cmd_pkg::cmd_t cmd);
    logic [15:0] st;
    issue_command(cmd);
    wait_not_busy(st);
    check_true(st == 16'h0000, $sformatf("status %04h after write %04h", st, cmd));
  endtask

  task automatic run_read(input uart_cmd_pkg::cmd_t cmd);
    logic [15:0] st;
    logic [15:0] rd;
    issue_command(cmd);
    wait_not_busy(st);
    check_true(st == 16'h0002, $sformatf("status %04h after read %04h", st, cmd));
    wb_read(uart_cmd_pkg::addr_rdata, rd);
    check_true(rd == {8'h00, peer_response(cmd[15:8])},
               $sformatf("rdata %04h, expected %02h", rd, peer_response(cmd[15:8])));
    wb_read(uart_cmd_pkg::addr_status, st);
    check_true(st == 16'h0000, $sformatf("status %04h after rdata read", st));
  endtask

  task automatic begin_test(input string name);
    test_num++;
    test_name        = name;
    test_first_error = errors;
  endtask

  task automatic end_test();
    check_true(exp_q.size() == 0,
               $sformatf("%0d expected bytes never appeared on tx", exp_q.size()));
    exp_q.delete();
    if (errors == test_first_error) begin
      pass_count++;
      $display("test %0d %s: pass", test_num, test_name);
    end else begin
      fail_count++;
      $display("test %0d %s: fail", test_num, test_name);
    end
  endtask

  initial begin
    logic [15:0]        st;
    logic [15:0]        rd;
    logic [31:0]        rnd;
    uart_cmd_pkg::cmd_t cmd;
    int unsigned        seed;
    seed       = 32'hb2695d30;
    rnd        = $urandom(seed);
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    bad_parity = 1'b0;
    silent     = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset state");
    check_true(tx === 1'b1, "tx not idle high after reset");
    wb_read(uart_cmd_pkg::addr_status, st);
    check_true(st == 16'h0000, $sformatf("status %04h after reset", st));
    repeat (2 * frame_cycles) @(negedge clk);
    wb_read(uart_cmd_pkg::addr_status, st);
    check_true(st == 16'h0000, $sformatf("status %04h after idle rx", st));
    end_test();

    begin_test("write command");
    run_write(16'ha53c);
    end_test();

    begin_test("read command");
    run_read(16'h3c96);
    end_test();

    begin_test("response parity error");
    bad_parity = 1'b1;
    issue_command(16'h2a11);
    wait_not_busy(st);
    check_true(st[uart_cmd_pkg::st_parity_err] == 1'b1, "parity_err not set");
    check_true(st[uart_cmd_pkg::st_rdata_valid] == 1'b0, "rdata_valid set on bad parity");
    // the byte is still returned, only parity was corrupted
    wb_read(uart_cmd_pkg::addr_rdata, rd);
    check_true(rd == {8'h00, peer_response(8'h2a)},
               $sformatf("rdata %04h after bad parity, expected %02h", rd,
                         peer_response(8'h2a)));
    bad_parity = 1'b0;
    issue_command(16'h9234);
    wb_read(uart_cmd_pkg::addr_status, st);
    check_true(st[uart_cmd_pkg::st_parity_err] == 1'b0, "parity_err kept after new command");
    wait_not_busy(st);
    check_true(st == 16'h0000, $sformatf("status %04h after write", st));
    end_test();

    begin_test("response timeout");
    silent = 1'b1;
    issue_command(16'h4d77);
    wb_read(uart_cmd_pkg::addr_status, st);
    check_true(st[uart_cmd_pkg::st_busy] == 1'b1, "busy not set during read");
    // dropped by the register block, so nothing goes on the expected list
    wb_write(uart_cmd_pkg::addr_cmd, 16'hc3e1);
    wait_not_busy(st);
    check_true(st == 16'h0010, $sformatf("status %04h after silent read", st));
    repeat (2 * frame_cycles) @(negedge clk);
    silent = 1'b0;
    end_test();

    begin_test("random commands");
    for (int n = 0; n < 30; n++) begin
      rnd     = $urandom;
      cmd     = rnd[15:0];
      cmd[15] = rnd[16];
      if (cmd[uart_cmd_pkg::cmd_write_bit]) begin
        run_write(cmd);
      end else begin
        run_read(cmd);
      end
    end
    end_test();

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/uart_frame_pkg.sv
src/uart_cmd_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/cmd_sequencer.sv
src/wb_cmd_regs.sv
src/uart_cmd_top.sv
verif/uart_peer_model.sv
verif/tb_uart_cmd.sv
